//--- logic/fp_cast_cfg.svh
`ifndef FP_CAST_CFG_SVH
`define FP_CAST_CFG_SVH

// binary32 <-> int32 converter sizing

// operand and result width
`define FP_CAST_WIDTH 32

// binary32 fields
`define FP_CAST_EXP_BITS 8
`define FP_CAST_MAN_BITS 23
`define FP_CAST_BIAS     127

// --------------------------------------------------
// internal datapath
// --------------------------------------------------
// max of hidden bit + fraction and full integer
`define FP_CAST_INT_MAN_WIDTH 32
// signed, covers smallest subnormal and int shifts
`define FP_CAST_INT_EXP_WIDTH 10
// leading-zero count / renorm shift
`define FP_CAST_LZC_WIDTH 5

`endif

//--- logic/fp_cast_pkg.sv
`default_nettype none

`include "fp_cast_cfg.svh"

package fp_cast_pkg;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic {
    F2I = 1'b0,  // float to integer
    I2F = 1'b1   // integer to float
  } operation_e;

  // RISC-V rounding-mode encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,  // nearest, ties to even
    RTZ = 3'd1,  // toward zero
    RDN = 3'd2,  // toward -inf
    RUP = 3'd3,  // toward +inf
    RMM = 3'd4   // nearest, ties away from zero
  } roundmode_e;

  typedef struct packed {
    logic nv;  // invalid
    logic dz;  // never raised by a cast
    logic of;
    logic uf;
    logic nx;  // inexact
  } status_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // --------------------------------------------------
  // stage payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [`FP_CAST_WIDTH-1:0] operand;
    operation_e                op;
    logic                      op_mod;    // set: integer side is unsigned
    roundmode_e                rnd_mode;
  } cast_req_t;

  typedef struct packed {
    logic [`FP_CAST_WIDTH-1:0] result;
    status_t                   status;
  } cast_rsp_t;

  typedef struct packed {
    logic                              sign;
    logic [`FP_CAST_INT_EXP_WIDTH-1:0] exp;          // unbiased, two's complement
    logic [`FP_CAST_INT_MAN_WIDTH-1:0] mant;         // msb is the leading one
    logic                              mant_is_zero;
    fp_info_t                          info;
    operation_e                        op;
    logic                              op_mod;
    roundmode_e                        rnd_mode;
  } norm_t;

  typedef struct packed {
    logic                         sign;
    logic [`FP_CAST_EXP_BITS-1:0] final_exp;
    logic [`FP_CAST_MAN_BITS-1:0] final_mant;
    logic [`FP_CAST_WIDTH-1:0]    final_int;
    logic [1:0]                   fp_round_sticky;   // {round, sticky}
    logic [1:0]                   int_round_sticky;
    logic                         of_before_round;
    logic                         uf_before_round;
    logic                         mant_is_zero;
    fp_info_t                     info;
    operation_e                   op;
    logic                         op_mod;
    roundmode_e                   rnd_mode;
  } aligned_t;

endpackage

`default_nettype wire

//--- logic/fp_cast_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fp_cast_stage #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  // upstream side
  input  wire logic     valid_i,
  output logic          ready_o,
  input  wire payload_t data_i,
  // downstream side
  output logic          valid_o,
  input  wire logic     ready_i,
  output payload_t      data_o
);

  // empty, or the held item leaves this cycle
  assign ready_o = ~valid_o | ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;  // refill or drain
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/fp_cast_normalize.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_cast_cfg.svh"

module fp_cast_normalize (
  input  wire fp_cast_pkg::cast_req_t req_i,
  output fp_cast_pkg::norm_t          norm_o
);

  localparam int unsigned WIDTH    = `FP_CAST_WIDTH;
  localparam int unsigned EXP_BITS = `FP_CAST_EXP_BITS;
  localparam int unsigned MAN_BITS = `FP_CAST_MAN_BITS;
  localparam int unsigned MW       = `FP_CAST_INT_MAN_WIDTH;
  localparam int unsigned IEW      = `FP_CAST_INT_EXP_WIDTH;
  localparam int unsigned LZW      = `FP_CAST_LZC_WIDTH;
  // float mantissa sits at the bottom of the MW-wide field
  localparam int unsigned SHIFT_COMP = MW - 1 - MAN_BITS;

  logic [EXP_BITS-1:0]   exp_field;
  logic [MAN_BITS-1:0]   frac;
  fp_cast_pkg::fp_info_t info;

  logic          is_i2f;
  logic          int_sign;
  logic [MW-1:0] int_value;  // sign-extended operand
  logic [MW-1:0] int_mag;
  logic [MW-1:0] enc_mant;   // before renorm
  logic [LZW-1:0] lzc;

  int fp_exp;
  int int_exp;

  assign is_i2f    = (req_i.op == fp_cast_pkg::I2F);
  assign exp_field = req_i.operand[MAN_BITS +: EXP_BITS];
  assign frac      = req_i.operand[MAN_BITS-1:0];

  // --------------------------------------------------
  // classify binary32 operand
  // --------------------------------------------------
  always_comb begin
    info.is_normal     = (exp_field != '0) && (exp_field != '1);
    info.is_subnormal  = (exp_field == '0) && (frac != '0);
    info.is_zero       = (exp_field == '0) && (frac == '0);
    info.is_inf        = (exp_field == '1) && (frac == '0);
    info.is_nan        = (exp_field == '1) && (frac != '0);
    info.is_signalling = info.is_nan && !frac[MAN_BITS-1];  // quiet bit clear
  end

  // integer magnitude, unsigned inputs never negative
  always_comb begin
    int_value            = {MW{req_i.operand[WIDTH-1] & ~req_i.op_mod}};
    int_value[WIDTH-1:0] = req_i.operand;
    int_sign             = int_value[MW-1] & ~req_i.op_mod;
    int_mag              = int_sign ? -int_value : int_value;
  end

  // hidden bit only for normals
  assign enc_mant = is_i2f ? int_mag : MW'({info.is_normal, frac});

  // --------------------------------------------------
  // leading-zero count
  // --------------------------------------------------
  always_comb begin
    lzc = '0;
    for (int i = 0; i < MW; i++) begin
      if (enc_mant[i]) begin
        lzc = LZW'(MW - 1 - i);  // highest set bit wins
      end
    end
  end

  // unbias and undo the renorm shift
  always_comb begin
    fp_exp  = int'(exp_field) + int'(info.is_subnormal) - `FP_CAST_BIAS
              - int'(lzc) + int'(SHIFT_COMP);
    int_exp = int'(MW) - 1 - int'(lzc);
  end

  always_comb begin
    norm_o.sign         = is_i2f ? int_sign : req_i.operand[WIDTH-1];
    norm_o.exp          = IEW'(is_i2f ? int_exp : fp_exp);
    norm_o.mant         = enc_mant << lzc;   // leading one to msb
    norm_o.mant_is_zero = (enc_mant == '0);  // int zero, no one to find
    norm_o.info         = info;
    norm_o.op           = req_i.op;
    norm_o.op_mod       = req_i.op_mod;
    norm_o.rnd_mode     = req_i.rnd_mode;
  end

endmodule

`default_nettype wire

//--- logic/fp_cast_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_cast_cfg.svh"

module fp_cast_align (
  input  wire fp_cast_pkg::norm_t norm_i,
  output fp_cast_pkg::aligned_t   aligned_o
);

  localparam int unsigned WIDTH    = `FP_CAST_WIDTH;
  localparam int unsigned EXP_BITS = `FP_CAST_EXP_BITS;
  localparam int unsigned MAN_BITS = `FP_CAST_MAN_BITS;
  localparam int unsigned MW       = `FP_CAST_INT_MAN_WIDTH;
  localparam int unsigned IEW      = `FP_CAST_INT_EXP_WIDTH;
  localparam int unsigned SHW      = $clog2(MW + 1);  // shift amount width
  localparam int          MAX_EXP  = 2**EXP_BITS - 1; // inf/nan exponent

  localparam int unsigned NUM_FP_STICKY  = 2 * MW - MAN_BITS - 1;  // below fraction and R
  localparam int unsigned NUM_INT_STICKY = 2 * MW - WIDTH;         // below integer and R

  localparam logic signed [IEW-1:0] BIAS = `FP_CAST_BIAS;

  logic                  dst_is_int;
  logic signed [IEW-1:0] input_exp;
  logic signed [IEW-1:0] dest_exp;   // rebiased for binary32

  logic [2*MW:0]       preshift_mant;
  logic [2*MW:0]       dest_mant;
  logic [SHW-1:0]      shamt;
  logic [EXP_BITS-1:0] final_exp;
  logic                of_before_round;
  logic                uf_before_round;

  assign dst_is_int = (norm_i.op == fp_cast_pkg::F2I);
  assign input_exp  = $signed(norm_i.exp);
  assign dest_exp   = input_exp + BIAS;

  // --------------------------------------------------
  // shift amount and range checks
  // --------------------------------------------------
  always_comb begin
    final_exp       = dest_exp[EXP_BITS-1:0];
    preshift_mant   = {norm_i.mant, {(MW+1){1'b0}}};  // left in the shifter
    shamt           = '0;
    of_before_round = 1'b0;
    uf_before_round = 1'b0;

    if (dst_is_int) begin
      shamt = SHW'(int'(WIDTH) - 1 - int'(input_exp));
      // unsigned range is one bit larger
      if (int'(input_exp) >= int'(WIDTH) - 1 + int'(norm_i.op_mod)) begin
        shamt           = '0;
        of_before_round = 1'b1;
      end else if (int'(input_exp) < -1) begin
        shamt           = SHW'(WIDTH + 1);  // whole value to sticky
        uf_before_round = 1'b1;
      end
    end else begin
      if (int'(dest_exp) >= MAX_EXP) begin
        final_exp       = EXP_BITS'(MAX_EXP - 1);  // largest normal
        preshift_mant   = '1;                      // all mantissa and RS ones
        of_before_round = 1'b1;
      end else if (int'(dest_exp) < 1) begin
        final_exp       = '0;  // subnormal result
        uf_before_round = 1'b1;
        if (int'(dest_exp) >= -int'(MAN_BITS)) begin
          shamt = SHW'(1 - int'(dest_exp));
        end else begin
          shamt = SHW'(2 + MAN_BITS);  // keep it in sticky
        end
      end
    end
  end

  assign dest_mant = preshift_mant >> shamt;

  // --------------------------------------------------
  // extract fields, collapse the tail
  // --------------------------------------------------
  always_comb begin
    aligned_o.sign                = norm_i.sign;
    aligned_o.final_exp           = final_exp;
    aligned_o.final_mant          = dest_mant[2*MW-1 -: MAN_BITS];  // hidden bit dropped
    aligned_o.fp_round_sticky[1]  = dest_mant[2*MW-1-MAN_BITS];
    aligned_o.fp_round_sticky[0]  = |dest_mant[NUM_FP_STICKY-1:0];
    aligned_o.final_int           = dest_mant[2*MW -: WIDTH];
    aligned_o.int_round_sticky[1] = dest_mant[2*MW-WIDTH];
    aligned_o.int_round_sticky[0] = |dest_mant[NUM_INT_STICKY-1:0];
    aligned_o.of_before_round     = of_before_round;
    aligned_o.uf_before_round     = uf_before_round;
    aligned_o.mant_is_zero        = norm_i.mant_is_zero;
    aligned_o.info                = norm_i.info;
    aligned_o.op                  = norm_i.op;
    aligned_o.op_mod              = norm_i.op_mod;
    aligned_o.rnd_mode            = norm_i.rnd_mode;
  end

endmodule

`default_nettype wire

//--- logic/fp_cast_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_cast_cfg.svh"

module fp_cast_round (
  input  wire fp_cast_pkg::aligned_t aligned_i,
  output fp_cast_pkg::cast_rsp_t     rsp_o
);

  localparam int unsigned WIDTH    = `FP_CAST_WIDTH;
  localparam int unsigned EXP_BITS = `FP_CAST_EXP_BITS;
  localparam int unsigned MAN_BITS = `FP_CAST_MAN_BITS;

  logic             dst_is_int;
  logic [1:0]       round_sticky;
  logic [WIDTH-1:0] pre_round_abs;  // magnitude before rounding
  logic             round_up;
  logic [WIDTH-1:0] rounded_abs;

  logic [WIDTH-1:0] rounded_int_res;  // two's complement
  logic [WIDTH-1:0] int_special_res;
  logic             int_is_special;
  logic [WIDTH-1:0] fp_result;

  fp_cast_pkg::status_t int_status;
  fp_cast_pkg::status_t fp_status;

  assign dst_is_int   = (aligned_i.op == fp_cast_pkg::F2I);
  assign round_sticky = dst_is_int ? aligned_i.int_round_sticky : aligned_i.fp_round_sticky;

  assign pre_round_abs = dst_is_int ? aligned_i.final_int
                                    : WIDTH'({aligned_i.final_exp, aligned_i.final_mant});

  // --------------------------------------------------
  // rounding increment
  // --------------------------------------------------
  always_comb begin
    case (aligned_i.rnd_mode)
      fp_cast_pkg::RNE: begin
        case (round_sticky)
          2'b10:   round_up = pre_round_abs[0];  // tie, go to even
          2'b11:   round_up = 1'b1;
          default: round_up = 1'b0;
        endcase
      end
      fp_cast_pkg::RTZ: round_up = 1'b0;
      fp_cast_pkg::RDN: round_up = (|round_sticky) & aligned_i.sign;
      fp_cast_pkg::RUP: round_up = (|round_sticky) & ~aligned_i.sign;
      fp_cast_pkg::RMM: round_up = round_sticky[1];  // ties away
      default:          round_up = 1'b0;             // reserved modes
    endcase
  end

  assign rounded_abs = pre_round_abs + WIDTH'(round_up);

  // --------------------------------------------------
  // integer result and special cases
  // --------------------------------------------------
  assign rounded_int_res = aligned_i.sign ? -rounded_abs : rounded_abs;

  always_comb begin
    int_special_res[WIDTH-2:0] = '1;                // signed max
    int_special_res[WIDTH-1]   = aligned_i.op_mod;  // unsigned max
    // negatives saturate to min or 0, nan stays positive
    if (aligned_i.sign && !aligned_i.info.is_nan) begin
      int_special_res = ~int_special_res;
    end
  end

  // negative unsigned is only legal when it rounds to zero
  assign int_is_special = aligned_i.info.is_nan | aligned_i.info.is_inf |
                          aligned_i.of_before_round |
                          (aligned_i.sign & aligned_i.op_mod & (rounded_int_res != '0));

  always_comb begin
    if (int_is_special) begin
      int_status = '{nv: 1'b1, default: 1'b0};  // invalid alone
    end else begin
      int_status = '{nx: |aligned_i.int_round_sticky, default: 1'b0};
    end
  end

  // --------------------------------------------------
  // float result
  // --------------------------------------------------
  // int zero has no leading one, force +0
  assign fp_result = aligned_i.mant_is_zero ? '0
                                            : {aligned_i.sign, rounded_abs[WIDTH-2:0]};

  always_comb begin
    fp_status    = '0;  // no nv, dz or of from I2F
    // tiny after rounding and inexact
    fp_status.uf = aligned_i.uf_before_round &
                   (rounded_abs[MAN_BITS +: EXP_BITS] == '0) &
                   (|aligned_i.fp_round_sticky);
    fp_status.nx = |aligned_i.fp_round_sticky;
  end

  // final select by destination
  always_comb begin
    if (dst_is_int) begin
      rsp_o.result = int_is_special ? int_special_res : rounded_int_res;
      rsp_o.status = int_status;
    end else begin
      rsp_o.result = fp_result;
      rsp_o.status = fp_status;
    end
  end

endmodule

`default_nettype wire

//--- logic/fp_cast.sv
`timescale 1ns/1ps
`default_nettype none

module fp_cast (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // request channel
  input  wire fp_cast_pkg::cast_req_t req_i,
  input  wire logic                   in_valid_i,
  output logic                        in_ready_o,
  // response channel
  output fp_cast_pkg::cast_rsp_t      rsp_o,
  output logic                        out_valid_o,
  input  wire logic                   out_ready_i,
  // something in flight
  output logic                        busy_o
);

  fp_cast_pkg::cast_req_t req_q;     // registered request
  logic                   req_valid;
  logic                   req_ready; // out stage can take a result

  fp_cast_pkg::norm_t     norm;
  fp_cast_pkg::aligned_t  aligned;
  fp_cast_pkg::cast_rsp_t rsp_d;     // combinational result

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  fp_cast_stage #(
    .payload_t ( fp_cast_pkg::cast_req_t )
  ) u_in_stage (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_i  ( req_i      ),
    .valid_o ( req_valid  ),
    .ready_i ( req_ready  ),
    .data_o  ( req_q      )
  );

  // zero-cycle datapath between the registers
  fp_cast_normalize u_normalize (
    .req_i  ( req_q ),
    .norm_o ( norm  )
  );

  fp_cast_align u_align (
    .norm_i    ( norm    ),
    .aligned_o ( aligned )
  );

  fp_cast_round u_round (
    .aligned_i ( aligned ),
    .rsp_o     ( rsp_d   )
  );

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  fp_cast_stage #(
    .payload_t ( fp_cast_pkg::cast_rsp_t )
  ) u_out_stage (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid   ),
    .ready_o ( req_ready   ),
    .data_i  ( rsp_d       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_o       )
  );

  assign busy_o = req_valid | out_valid_o;  // either stage occupied

endmodule

`default_nettype wire

//--- bench/tb_fp_cast.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_cast_cfg.svh"

module tb_fp_cast;

  localparam int MAX_VECTORS = 64;
  localparam int FIELDS      = 6;  // words per golden line
  localparam int LATENCY     = 2;  // accept edge to response edge with ready held high

  logic                   clk_i;
  logic                   rst_i;
  fp_cast_pkg::cast_req_t req_i;
  logic                   in_valid_i;
  logic                   in_ready_o;
  fp_cast_pkg::cast_rsp_t rsp_o;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic                   busy_o;

  logic [31:0] golden_mem [0:MAX_VECTORS*FIELDS-1];  // six words per vector

  int     num_vectors     = 0;
  int     timeout_cycles  = 0;  // 0 until the vector count is known
  int     cycle_count     = 0;
  integer seed            = 32'haad5_9228;
  bit     backpressure_on = 1'b0;

  // expected responses in request order
  fp_cast_pkg::cast_rsp_t exp_q[$];
  int                     accept_q[$];  // accept edge or -1 when latency unchecked
  int                     index_q[$];   // vector number for error lines

  fp_cast u_fp_cast (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  // --------------------------------------------------
  // checks and failure exit
  // --------------------------------------------------
  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input logic [`FP_CAST_WIDTH-1:0] got,
                              input logic [`FP_CAST_WIDTH-1:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      stop_on_error();
    end
  endtask

  task automatic check_status(input string name, input fp_cast_pkg::status_t got,
                              input fp_cast_pkg::status_t expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      stop_on_error();
    end
  endtask

  always @(posedge clk_i) begin
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
      $display("timeout: responses missing");
      stop_on_error();
    end
  end

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  // drives one golden vector and holds it until accepted
  task automatic send_vector(input int idx, input bit timed);
    int                     base;
    fp_cast_pkg::cast_req_t req;
    fp_cast_pkg::cast_rsp_t rsp;
    base         = FIELDS * idx;
    req.op       = fp_cast_pkg::operation_e'(golden_mem[base][0]);
    req.op_mod   = golden_mem[base+1][0];
    req.rnd_mode = fp_cast_pkg::roundmode_e'(golden_mem[base+2][2:0]);
    req.operand  = golden_mem[base+3];
    rsp.result   = golden_mem[base+4];
    rsp.status   = fp_cast_pkg::status_t'(golden_mem[base+5][4:0]);
    @(negedge clk_i);
    req_i      = req;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    if (timed) begin
      check_flag("in_ready_o", in_ready_o, 1'b1);  // one per cycle without back-pressure
    end
    while (!in_ready_o) begin
      @(posedge clk_i);
    end
    exp_q.push_back(rsp);
    accept_q.push_back(timed ? cycle_count : -1);
    index_q.push_back(idx);
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // --------------------------------------------------
  // response side
  // --------------------------------------------------
  initial begin : drive_out_ready
    logic [31:0] rnd;
    forever begin
      @(negedge clk_i);
      if (backpressure_on) begin
        rnd         = $random(seed);
        out_ready_i = rnd[0];  // about half the cycles stalled
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  initial begin : receive_responses
    fp_cast_pkg::cast_rsp_t expected;
    int                     accepted_at;
    int                     idx;
    forever begin
      @(posedge clk_i);
      if (!rst_i && out_valid_o) begin
        check_flag("busy_o", busy_o, 1'b1);  // output stage occupied
      end
      if (!rst_i && out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("response arrived with no request pending");
          stop_on_error();
        end
        expected    = exp_q.pop_front();
        accepted_at = accept_q.pop_front();
        idx         = index_q.pop_front();
        check_result($sformatf("rsp_o.result (vector %0d)", idx), rsp_o.result,
                     expected.result);
        check_status($sformatf("rsp_o.status (vector %0d)", idx), rsp_o.status,
                     expected.status);
        if (accepted_at >= 0 && cycle_count - accepted_at != LATENCY) begin
          $display("vector %0d took %0d cycles instead of %0d", idx,
                   cycle_count - accepted_at, LATENCY);
          stop_on_error();
        end
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : run_test
    int i;
    rst_i       = 1'b1;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;

    $readmemh("bench/fp_cast_golden.mem", golden_mem);
    while (num_vectors < MAX_VECTORS && !$isunknown(golden_mem[FIELDS*num_vectors])) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("no vectors found in bench/fp_cast_golden.mem");
      stop_on_error();
    end
    timeout_cycles = 20 * num_vectors + 100;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // idle state after reset
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);

    // back-to-back with ready held high and latency checked
    for (i = 0; i < num_vectors; i++) begin
      send_vector(i, 1'b1);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    drain_responses();

    // same vectors again under random back-pressure
    @(posedge clk_i);
    backpressure_on = 1'b1;
    for (i = 0; i < num_vectors; i++) begin
      send_vector(i, 1'b0);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    drain_responses();

    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- fp_cast.f
+incdir+logic
logic/fp_cast_pkg.sv
logic/fp_cast_stage.sv
logic/fp_cast_normalize.sv
logic/fp_cast_align.sv
logic/fp_cast_round.sv
logic/fp_cast.sv
bench/tb_fp_cast.sv

//--- bench/fp_cast_golden.mem
// op op_mod rnd_mode operand expected_result expected_status
// op 0 F2I 1 I2F, rnd 0..4 RNE RTZ RDN RUP RMM, status bits {nv dz of uf nx}
// F2I of 2.5 in all modes
0 0 0 40200000 00000002 01
0 0 1 40200000 00000002 01
0 0 2 40200000 00000002 01
0 0 3 40200000 00000003 01
0 0 4 40200000 00000003 01
// F2I of -2.5 in all modes
0 0 0 C0200000 FFFFFFFE 01
0 0 1 C0200000 FFFFFFFE 01
0 0 2 C0200000 FFFFFFFD 01
0 0 3 C0200000 FFFFFFFE 01
0 0 4 C0200000 FFFFFFFD 01
// F2I exact and simple inexact values
0 0 0 3F800000 00000001 00
0 0 0 3FC00000 00000002 01
0 0 1 4E6E6B28 3B9ACA00 00
0 0 0 00000000 00000000 00
0 0 3 00000001 00000001 01
// F2I saturation and invalid cases
0 0 0 7FC00000 7FFFFFFF 10
0 0 0 FFC00000 7FFFFFFF 10
0 1 0 7FC00000 FFFFFFFF 10
0 0 1 7F800000 7FFFFFFF 10
0 0 1 FF800000 80000000 10
0 0 0 4F000000 7FFFFFFF 10
0 1 0 4F000000 80000000 00
0 1 0 BF800000 00000000 10
0 1 1 BE99999A 00000000 01
// I2F exact values
1 0 0 FFFFFFFF BF800000 00
1 0 0 00000000 00000000 00
1 0 0 00000003 40400000 00
1 0 0 80000000 CF000000 00
1 0 0 3B9ACA00 4E6E6B28 00
// I2F of 2^24 + 1 in all modes
1 0 0 01000001 4B800000 01
1 0 1 01000001 4B800000 01
1 0 2 01000001 4B800000 01
1 0 3 01000001 4B800001 01
1 0 4 01000001 4B800001 01
// I2F inexact, unsigned max and negative
1 1 0 FFFFFFFF 4F800000 01
1 1 1 FFFFFFFF 4F7FFFFF 01
1 0 2 FEFFFFFF CB800001 01
